// File: common/dispatch_config.svh
// Dispatch stage configuration
// Register file sizes, reorder-buffer depth and the index widths
// that follow from them

`ifndef DISPATCH_CONFIG_SVH
`define DISPATCH_CONFIG_SVH

// Register counts
`define ARCH_REGS 32
`define PHYS_REGS 64

// Reorder-buffer depth
`define ROB_SZ 16

// Pregs not holding architectural state at reset
`define FREE_SZ (`PHYS_REGS - `ARCH_REGS)

// Index widths
`define ARCH_IDX_W 5
`define PREG_IDX_W 6
`define ROB_IDX_W 4
`define FREE_IDX_W 5

`endif

// File: common/dispatch_pkg.sv
// Dispatch stage types
// Register index types, function classes and the packets passed between
// fetch, rename, the reorder buffer and issue

`include "dispatch_config.svh"

package dispatch_pkg;

    // Index types
    typedef logic [`ARCH_IDX_W-1:0] arch_idx_t;
    typedef logic [`PREG_IDX_W-1:0] preg_idx_t;
    typedef logic [`ROB_IDX_W-1:0]  rob_idx_t;

    // Physical register with its ready bit
    typedef struct packed {
        preg_idx_t num;
        logic      ready;
    } preg_t;

    // Functional unit class
    typedef enum logic [2:0] {
        ALU    = 3'd0,
        MULT   = 3'd1,
        LOAD   = 3'd2,
        STORE  = 3'd3,
        BRANCH = 3'd4
    } func_type_t;

    // From fetch
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] inst;
    } fetch_packet_t;

    // Decoder result
    typedef struct packed {
        arch_idx_t  rs1;
        arch_idx_t  rs2;
        arch_idx_t  rd;
        logic       uses_rs1;
        logic       uses_rs2;
        logic       has_dest;
        logic       illegal;
        func_type_t func;
    } decode_t;

    // Renamed instruction towards issue
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        rob_idx_t    rob_idx;
        preg_t       src1;
        preg_t       src2;
        preg_idx_t   dest;
        logic        has_dest;
        func_type_t  func;
    } dispatch_packet_t;

    // One reorder-buffer slot
    typedef struct packed {
        arch_idx_t rd;
        preg_idx_t new_preg;
        preg_idx_t old_preg;
        logic      has_dest;
    } rob_entry_t;

endpackage

// File: hw/inst_decoder.sv
// RV32I instruction decoder
// Pulls out register fields, source and destination use and the
// functional unit class, and flags unknown opcodes as illegal
`timescale 1ns/1ns

module inst_decoder (
    input  logic [31:0]           inst,
    output dispatch_pkg::decode_t dec
);
    import dispatch_pkg::*;

    // Base opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    // Opcode writes a register
    logic writes;

    always_comb begin
        dec      = '0;
        dec.rs1  = inst[19:15];
        dec.rs2  = inst[24:20];
        dec.rd   = inst[11:7];
        dec.func = ALU;
        writes   = 1'b0;

        case (inst[6:0])
            OPC_OP: begin
                dec.uses_rs1 = 1'b1;
                dec.uses_rs2 = 1'b1;
                writes       = 1'b1;
                // M extension lives under funct7 = 1
                dec.func     = (inst[31:25] == 7'b0000001) ? MULT : ALU;
            end
            OPC_OP_IMM: begin
                dec.uses_rs1 = 1'b1;
                writes       = 1'b1;
            end
            OPC_LOAD: begin
                dec.uses_rs1 = 1'b1;
                writes       = 1'b1;
                dec.func     = LOAD;
            end
            OPC_STORE: begin
                dec.uses_rs1 = 1'b1;
                dec.uses_rs2 = 1'b1;
                dec.func     = STORE;
            end
            OPC_BRANCH: begin
                dec.uses_rs1 = 1'b1;
                dec.uses_rs2 = 1'b1;
                dec.func     = BRANCH;
            end
            OPC_LUI, OPC_AUIPC: begin
                writes = 1'b1;
            end
            OPC_JAL: begin
                writes   = 1'b1;
                dec.func = BRANCH;
            end
            OPC_JALR: begin
                dec.uses_rs1 = 1'b1;
                writes       = 1'b1;
                dec.func     = BRANCH;
            end
            default: dec.illegal = 1'b1;
        endcase

        // x0 is never renamed
        dec.has_dest = writes && (inst[11:7] != 5'd0);
    end

endmodule

// File: hw/rename/map_table.sv
// Register map table
// Speculative arch-to-preg map with ready bits plus the committed
// architectural map used to restore state on rollback
`timescale 1ns/1ns
`include "dispatch_config.svh"

module map_table (
    input  logic                    clock,
    input  logic                    reset,
    input  dispatch_pkg::arch_idx_t rs1,
    input  dispatch_pkg::arch_idx_t rs2,
    input  dispatch_pkg::arch_idx_t rd,
    input  logic                    set_dest,
    input  dispatch_pkg::preg_idx_t new_preg,
    input  logic                    cdb_valid,
    input  dispatch_pkg::preg_idx_t cdb_preg,
    input  logic                    commit,
    input  dispatch_pkg::arch_idx_t commit_rd,
    input  dispatch_pkg::preg_idx_t commit_preg,
    input  logic                    restore,
    output dispatch_pkg::preg_t     src1,
    output dispatch_pkg::preg_t     src2,
    output dispatch_pkg::preg_idx_t old_preg
);
    import dispatch_pkg::*;

    preg_t     spec_map [`ARCH_REGS];
    preg_idx_t arch_map [`ARCH_REGS];

    // Source lookup
    always_comb begin
        src1 = spec_map[rs1];
        src2 = spec_map[rs2];
        // Forward a broadcast landing this cycle
        if (cdb_valid && (src1.num == cdb_preg)) begin
            src1.ready = 1'b1;
        end
        if (cdb_valid && (src2.num == cdb_preg)) begin
            src2.ready = 1'b1;
        end
    end

    // Mapping being replaced, kept in the ROB for freeing at retire
    assign old_preg = spec_map[rd].num;

    // Speculative map
    always_ff @(posedge clock) begin
        if (reset) begin
            // Identity map, everything ready
            for (int i = 0; i < `ARCH_REGS; i++) begin
                spec_map[i] <= '{num: preg_idx_t'(i), ready: 1'b1};
            end
        end else if (restore) begin
            // Committed values are all ready
            for (int i = 0; i < `ARCH_REGS; i++) begin
                spec_map[i] <= '{num: arch_map[i], ready: 1'b1};
            end
        end else begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                if (cdb_valid && (spec_map[i].num == cdb_preg)) begin
                    spec_map[i].ready <= 1'b1;
                end
            end
            // New destination waits for its producer
            if (set_dest) begin
                spec_map[rd] <= '{num: new_preg, ready: 1'b0};
            end
        end
    end

    // Architectural map, written at commit only
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                arch_map[i] <= preg_idx_t'(i);
            end
        end else if (commit) begin
            arch_map[commit_rd] <= commit_preg;
        end
    end

endmodule

// File: hw/rename/free_list.sv
// Physical register free list
// Circular list handing out pregs in program order, with a rewind
// pointer trailing the head by the unretired allocations
`timescale 1ns/1ns
`include "dispatch_config.svh"

module free_list (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    dequeue,
    input  logic                    enqueue,
    input  dispatch_pkg::preg_idx_t enqueue_preg,
    input  logic                    retire_alloc,
    input  logic                    rewind,
    output dispatch_pkg::preg_idx_t head_preg,
    output logic                    empty
);
    import dispatch_pkg::*;

    preg_idx_t               list [`FREE_SZ];
    logic [`FREE_IDX_W-1:0]  head;
    logic [`FREE_IDX_W-1:0]  tail;
    logic [`FREE_IDX_W-1:0]  rewind_ptr;
    logic [`FREE_IDX_W:0]    count;

    assign head_preg = list[head];
    assign empty     = (count == '0);

    always_ff @(posedge clock) begin
        if (reset) begin
            // Pregs above the architectural range start out free
            for (int i = 0; i < `FREE_SZ; i++) begin
                list[i] <= preg_idx_t'(`ARCH_REGS + i);
            end
            head  <= '0;
            tail  <= '0;
            count <= (`FREE_IDX_W+1)'(`FREE_SZ);
        end else if (rewind) begin
            // Every unretired allocation comes back, so the list is full again
            head  <= rewind_ptr;
            count <= (`FREE_IDX_W+1)'(`FREE_SZ);
        end else begin
            if (dequeue) begin
                head <= head + 1'b1;
            end
            // Freed preg lands in the slot of the allocation just retired
            if (enqueue) begin
                list[tail] <= enqueue_preg;
                tail       <= tail + 1'b1;
            end
            case ({enqueue, dequeue})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Tracks the oldest allocation not yet retired
    always_ff @(posedge clock) begin
        if (reset) begin
            rewind_ptr <= '0;
        end else if (retire_alloc) begin
            rewind_ptr <= rewind_ptr + 1'b1;
        end
    end

endmodule

// File: hw/reorder_buffer.sv
// Reorder buffer
// Holds dispatched instructions in program order, presents the head
// for commit and drops everything speculative on rollback
`timescale 1ns/1ns
`include "dispatch_config.svh"

module reorder_buffer (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     write,
    input  dispatch_pkg::rob_entry_t entry,
    input  logic                     retire,
    input  logic                     rollback,
    output dispatch_pkg::rob_idx_t   tail_idx,
    output dispatch_pkg::rob_idx_t   head_idx,
    output dispatch_pkg::rob_entry_t head_entry,
    output logic                     commit,
    output logic                     full
);
    import dispatch_pkg::*;

    rob_entry_t            entries [`ROB_SZ];
    rob_idx_t              head;
    rob_idx_t              tail;
    logic [`ROB_IDX_W:0]   count;
    logic                  empty;

    assign empty = (count == '0);
    assign full  = (count == (`ROB_IDX_W+1)'(`ROB_SZ));

    assign tail_idx   = tail;
    assign head_idx   = head;
    assign head_entry = entries[head];

    // Retire on an empty buffer is ignored, rollback wins over retire
    assign commit = retire && !empty && !rollback;

    // Entry storage
    always_ff @(posedge clock) begin
        if (write) begin
            entries[tail] <= entry;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (rollback) begin
            // Drop all unretired entries
            tail  <= head;
            count <= '0;
        end else begin
            if (write) begin
                tail <= tail + 1'b1;
            end
            if (commit) begin
                head <= head + 1'b1;
            end
            case ({write, commit})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: hw/dispatch.sv
// Rename and dispatch stage
// Decodes one fetched instruction per cycle, renames its registers,
// allocates a ROB slot and emits the renamed packet in the same cycle
`timescale 1ns/1ns

module dispatch (
    input  logic                           clock,
    input  logic                           reset,
    input  dispatch_pkg::fetch_packet_t    fetch,
    input  logic                           cdb_valid,
    input  dispatch_pkg::preg_idx_t        cdb_preg,
    input  logic                           retire,
    input  logic                           rollback,
    input  logic                           downstream_full,
    output dispatch_pkg::dispatch_packet_t issue,
    output logic                           stall,
    output dispatch_pkg::rob_idx_t         rob_head_idx,
    output logic                           rob_full
);
    import dispatch_pkg::*;

    decode_t    dec;
    preg_t      mt_src1;
    preg_t      mt_src2;
    preg_idx_t  mt_old_preg;
    preg_idx_t  fl_head_preg;
    logic       fl_empty;
    rob_idx_t   rob_tail_idx;
    rob_entry_t rob_head_entry;
    rob_entry_t rob_new_entry;
    logic       rob_commit;
    logic       accept;
    logic       alloc;
    logic       free_old;

    inst_decoder u_decoder (
        .inst (fetch.inst),
        .dec  (dec)
    );

    // Stall on any missing resource
    assign stall = rob_full || (fl_empty && dec.has_dest) || downstream_full;

    // Illegal instructions fall through without a stall
    assign accept = fetch.valid && !dec.illegal && !stall && !rollback;
    assign alloc  = accept && dec.has_dest;

    // Committed destination updates the arch map and frees the old preg
    assign free_old = rob_commit && rob_head_entry.has_dest;

    map_table u_map_table (
        .clock       (clock),
        .reset       (reset),
        .rs1         (dec.rs1),
        .rs2         (dec.rs2),
        .rd          (dec.rd),
        .set_dest    (alloc),
        .new_preg    (fl_head_preg),
        .cdb_valid   (cdb_valid),
        .cdb_preg    (cdb_preg),
        .commit      (free_old),
        .commit_rd   (rob_head_entry.rd),
        .commit_preg (rob_head_entry.new_preg),
        .restore     (rollback),
        .src1        (mt_src1),
        .src2        (mt_src2),
        .old_preg    (mt_old_preg)
    );

    free_list u_free_list (
        .clock        (clock),
        .reset        (reset),
        .dequeue      (alloc),
        .enqueue      (free_old),
        .enqueue_preg (rob_head_entry.old_preg),
        .retire_alloc (free_old),
        .rewind       (rollback),
        .head_preg    (fl_head_preg),
        .empty        (fl_empty)
    );

    // ROB slot contents
    assign rob_new_entry = '{rd: dec.rd, new_preg: fl_head_preg,
                             old_preg: mt_old_preg, has_dest: dec.has_dest};

    reorder_buffer u_rob (
        .clock      (clock),
        .reset      (reset),
        .write      (accept),
        .entry      (rob_new_entry),
        .retire     (retire),
        .rollback   (rollback),
        .tail_idx   (rob_tail_idx),
        .head_idx   (rob_head_idx),
        .head_entry (rob_head_entry),
        .commit     (rob_commit),
        .full       (rob_full)
    );

    // Outgoing packet
    always_comb begin
        issue.valid    = accept;
        issue.pc       = fetch.pc;
        issue.rob_idx  = rob_tail_idx;
        // Unused sources read as x0, always ready
        issue.src1     = dec.uses_rs1 ? mt_src1 : '{num: '0, ready: 1'b1};
        issue.src2     = dec.uses_rs2 ? mt_src2 : '{num: '0, ready: 1'b1};
        issue.dest     = dec.has_dest ? fl_head_preg : '0;
        issue.has_dest = dec.has_dest;
        issue.func     = dec.func;
    end

endmodule

// File: verification/dispatch_tb.sv
// Testbench for the rename and dispatch stage
// A reference model keeps its own maps, free list, ROB and ready set,
// and concurrent assertions hold the DUT outputs to it every cycle
`timescale 1ns/1ns
`include "dispatch_config.svh"

module dispatch_tb;
    import dispatch_pkg::*;

    logic             clock;
    logic             reset;
    fetch_packet_t    fetch;
    logic             cdb_valid;
    preg_idx_t        cdb_preg;
    logic             retire;
    logic             rollback;
    logic             downstream_full;
    dispatch_packet_t issue;
    logic             stall;
    rob_idx_t         rob_head_idx;
    logic             rob_full;

    // Reference model state
    preg_idx_t  m_spec [`ARCH_REGS];
    preg_idx_t  m_arch [`ARCH_REGS];
    logic       m_ready [`PHYS_REGS];
    preg_idx_t  free_q [$];
    preg_idx_t  alloc_q [$];
    rob_entry_t rob_q [$];
    rob_idx_t   m_head;

    // Expected values for the coming edge
    dispatch_packet_t exp_issue;
    logic             exp_stall;
    logic             exp_full;
    rob_idx_t         exp_head;
    logic             m_accept;
    logic             m_has_dest;
    arch_idx_t        m_rd;

    logic [31:0] pc;
    logic        accepted;
    string       test_name;
    int          errors;
    int          timeouts;
    int          tests_run;
    int          tests_failed;
    int          fails_at_start;

    dispatch DUT (
        .clock           (clock),
        .reset           (reset),
        .fetch           (fetch),
        .cdb_valid       (cdb_valid),
        .cdb_preg        (cdb_preg),
        .retire          (retire),
        .rollback        (rollback),
        .downstream_full (downstream_full),
        .issue           (issue),
        .stall           (stall),
        .rob_head_idx    (rob_head_idx),
        .rob_full        (rob_full)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // Output checks against the model
    check_issue: assert property (@(posedge clock) disable iff (reset)
        (issue.valid == exp_issue.valid) && (!exp_issue.valid || issue == exp_issue))
    else begin
        $display("Mismatch in %s: issue expected %h actual %h",
                 test_name, $sampled(exp_issue), $sampled(issue));
        errors++;
    end

    check_stall: assert property (@(posedge clock) disable iff (reset) stall == exp_stall)
    else begin
        $display("Mismatch in %s: stall expected %b actual %b",
                 test_name, $sampled(exp_stall), $sampled(stall));
        errors++;
    end

    check_full: assert property (@(posedge clock) disable iff (reset) rob_full == exp_full)
    else begin
        $display("Mismatch in %s: rob_full expected %b actual %b",
                 test_name, $sampled(exp_full), $sampled(rob_full));
        errors++;
    end

    check_head: assert property (@(posedge clock) disable iff (reset) rob_head_idx == exp_head)
    else begin
        $display("Mismatch in %s: rob_head_idx expected %0d actual %0d",
                 test_name, $sampled(exp_head), $sampled(rob_head_idx));
        errors++;
    end

    // Register use and class straight from the RV32I encoding
    function automatic void decode_word(input logic [31:0] w, output logic ill,
                                        output logic use1, output logic use2,
                                        output logic dest, output func_type_t fn);
        logic writes;
        ill    = 1'b0;
        use1   = 1'b0;
        use2   = 1'b0;
        writes = 1'b0;
        fn     = ALU;
        case (w[6:0])
            7'b0110011: begin
                use1   = 1'b1;
                use2   = 1'b1;
                writes = 1'b1;
                fn     = (w[31:25] == 7'd1) ? MULT : ALU;
            end
            7'b0010011: begin
                use1   = 1'b1;
                writes = 1'b1;
            end
            7'b0000011: begin
                use1   = 1'b1;
                writes = 1'b1;
                fn     = LOAD;
            end
            7'b0100011: begin
                use1 = 1'b1;
                use2 = 1'b1;
                fn   = STORE;
            end
            7'b1100011: begin
                use1 = 1'b1;
                use2 = 1'b1;
                fn   = BRANCH;
            end
            7'b0110111, 7'b0010111: writes = 1'b1;
            7'b1101111: begin
                writes = 1'b1;
                fn     = BRANCH;
            end
            7'b1100111: begin
                use1   = 1'b1;
                writes = 1'b1;
                fn     = BRANCH;
            end
            default: ill = 1'b1;
        endcase
        // x0 gets no new preg
        dest = writes && (w[11:7] != 5'd0);
    endfunction

    // Speculative source with same-cycle CDB forwarding
    function automatic preg_t lookup(input arch_idx_t a);
        preg_t p;
        p.num   = m_spec[a];
        p.ready = m_ready[p.num] || (cdb_valid && cdb_preg == p.num);
        return p;
    endfunction

    task automatic predict_outputs();
        logic       ill;
        logic       use1;
        logic       use2;
        logic       hd;
        func_type_t fn;
        decode_word(fetch.inst, ill, use1, use2, hd, fn);
        exp_full   = (rob_q.size() == `ROB_SZ);
        exp_head   = m_head;
        exp_stall  = exp_full || (hd && free_q.size() == 0) || downstream_full;
        m_accept   = fetch.valid && !ill && !exp_stall && !rollback;
        m_has_dest = hd;
        m_rd       = fetch.inst[11:7];
        exp_issue  = '0;
        if (m_accept) begin
            exp_issue.valid    = 1'b1;
            exp_issue.pc       = fetch.pc;
            exp_issue.rob_idx  = m_head + rob_idx_t'(rob_q.size());
            exp_issue.src1     = use1 ? lookup(fetch.inst[19:15]) : '{num: '0, ready: 1'b1};
            exp_issue.src2     = use2 ? lookup(fetch.inst[24:20]) : '{num: '0, ready: 1'b1};
            exp_issue.dest     = hd ? free_q[0] : '0;
            exp_issue.has_dest = hd;
            exp_issue.func     = fn;
        end
    endtask

    // Model state change at a rising edge
    task automatic update_model();
        rob_entry_t e;
        preg_idx_t  p;
        if (rollback) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                m_spec[i]          = m_arch[i];
                m_ready[m_arch[i]] = 1'b1;
            end
            // Unretired allocations return ahead of the free pregs
            while (alloc_q.size() != 0) begin
                free_q.push_front(alloc_q.pop_back());
            end
            rob_q.delete();
        end else begin
            if (cdb_valid) begin
                m_ready[cdb_preg] = 1'b1;
            end
            if (retire && rob_q.size() != 0) begin
                e      = rob_q.pop_front();
                m_head = m_head + 1'b1;
                if (e.has_dest) begin
                    m_arch[e.rd] = e.new_preg;
                    free_q.push_back(e.old_preg);
                    void'(alloc_q.pop_front());
                end
            end
            if (m_accept) begin
                e = '{rd: m_rd, new_preg: '0, old_preg: m_spec[m_rd], has_dest: m_has_dest};
                if (m_has_dest) begin
                    p          = free_q.pop_front();
                    e.new_preg = p;
                    alloc_q.push_back(p);
                    m_spec[m_rd] = p;
                    m_ready[p]   = 1'b0;
                end
                rob_q.push_back(e);
            end
        end
    endtask

    // One clock cycle, entered and left on a falling edge
    task automatic tick();
        predict_outputs();
        #1;
        accepted = issue.valid;
        @(posedge clock);
        update_model();
        @(negedge clock);
        cdb_valid = 1'b0;
        retire    = 1'b0;
        rollback  = 1'b0;
    endtask

    task automatic present(input logic [31:0] inst);
        fetch.valid = 1'b1;
        fetch.pc    = pc;
        fetch.inst  = inst;
    endtask

    task automatic withdraw();
        fetch = '0;
        pc    = pc + 32'd4;
    endtask

    task automatic send(input logic [31:0] inst);
        present(inst);
        tick();
        withdraw();
    endtask

    function automatic arch_idx_t any_reg();
        return arch_idx_t'(1 + $urandom % 31);
    endfunction

    // R-type, ALU or MULT at random
    function automatic logic [31:0] op_word(input arch_idx_t rd, input arch_idx_t rs1,
                                            input arch_idx_t rs2);
        logic [6:0] funct7;
        funct7 = ($urandom % 2 == 0) ? 7'd0 : 7'd1;
        return {funct7, rs2, rs1, 3'b000, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] store_word(input arch_idx_t rs1, input arch_idx_t rs2);
        return {7'd0, rs2, rs1, 3'b010, 5'd0, 7'b0100011};
    endfunction

    // BEQ with a small forward offset
    function automatic logic [31:0] branch_word(input arch_idx_t rs1, input arch_idx_t rs2);
        return {7'd0, rs2, rs1, 3'b000, 5'd8, 7'b1100011};
    endfunction

    // OP-IMM, LOAD, LUI, AUIPC, JAL or JALR, picked by kind
    function automatic logic [31:0] imm_word(input int kind, input arch_idx_t rd,
                                             input arch_idx_t rs1);
        logic [6:0] opcode;
        case (kind % 6)
            0:       opcode = 7'b0010011;
            1:       opcode = 7'b0000011;
            2:       opcode = 7'b0110111;
            3:       opcode = 7'b0010111;
            4:       opcode = 7'b1101111;
            default: opcode = 7'b1100111;
        endcase
        return {12'h010, rs1, 3'b000, rd, opcode};
    endfunction

    task automatic start_test(input string name);
        test_name      = name;
        fails_at_start = errors + timeouts;
    endtask

    task automatic end_test();
        int n;
        n = errors + timeouts - fails_at_start;
        tests_run++;
        if (n == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d failures", test_name, n);
            tests_failed++;
        end
    endtask

    initial begin
        arch_idx_t r;
        int        n;
        void'($urandom(21));
        reset           = 1'b1;
        fetch           = '0;
        cdb_valid       = 1'b0;
        cdb_preg        = '0;
        retire          = 1'b0;
        rollback        = 1'b0;
        downstream_full = 1'b0;
        pc              = 32'h0000_1000;
        accepted        = 1'b0;
        test_name       = "reset";
        errors          = 0;
        timeouts        = 0;
        tests_run       = 0;
        tests_failed    = 0;
        fails_at_start  = 0;

        // Model after reset: identity map, upper pregs free
        for (int i = 0; i < `ARCH_REGS; i++) begin
            m_spec[i] = preg_idx_t'(i);
            m_arch[i] = preg_idx_t'(i);
        end
        for (int i = 0; i < `PHYS_REGS; i++) begin
            m_ready[i] = 1'b1;
        end
        for (int i = 0; i < `FREE_SZ; i++) begin
            free_q.push_back(preg_idx_t'(`ARCH_REGS + i));
        end
        m_head    = '0;
        exp_issue = '0;
        exp_stall = 1'b0;
        exp_full  = 1'b0;
        exp_head  = '0;

        repeat (3) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        start_test("reset_map");
        send(op_word(any_reg(), 5'd3, 5'd7));
        send(op_word(any_reg(), any_reg(), any_reg()));
        send(op_word(any_reg(), any_reg(), any_reg()));
        end_test();

        start_test("dependency");
        r = any_reg();
        send(op_word(r, 5'd1, 5'd2));
        // Reader sees the new preg still waiting
        send(op_word(5'd0, r, 5'd4));
        cdb_valid = 1'b1;
        cdb_preg  = m_spec[r];
        tick();
        send(op_word(5'd0, 5'd5, r));
        r = any_reg();
        send(op_word(r, 5'd6, 5'd8));
        // Broadcast lands in the lookup cycle
        cdb_valid = 1'b1;
        cdb_preg  = m_spec[r];
        send(op_word(5'd0, r, r));
        end_test();

        start_test("back_pressure");
        downstream_full = 1'b1;
        present(op_word(any_reg(), any_reg(), any_reg()));
        repeat (3) tick();
        downstream_full = 1'b0;
        n = 0;
        tick();
        while (!accepted && n < 10) begin
            tick();
            n++;
        end
        if (!accepted) begin
            $display("Timeout: held packet was not accepted after downstream_full dropped");
            timeouts++;
        end
        withdraw();
        // Unknown opcode, takes no slot and no preg
        send(32'hFFFF_FFFF);
        n = 0;
        while (!rob_full && n < 20) begin
            send(op_word(any_reg(), any_reg(), any_reg()));
            n++;
        end
        if (!rob_full) begin
            $display("Timeout: rob_full never rose while filling the ROB");
            timeouts++;
        end
        present(op_word(any_reg(), any_reg(), any_reg()));
        repeat (2) tick();
        withdraw();
        end_test();

        start_test("retire");
        for (int i = 0; i < `ROB_SZ; i++) begin
            retire = 1'b1;
            tick();
        end
        // Enough allocations to run past the initial pregs
        for (int i = 0; i < 24; i++) begin
            retire = 1'b1;
            if (i % 10 == 4) begin
                send(store_word(any_reg(), any_reg()));
            end else if (i % 10 == 9) begin
                send(branch_word(any_reg(), any_reg()));
            end else if (i % 3 == 0) begin
                // Single or no source, unused ones read as x0
                send(imm_word(i / 3, any_reg(), any_reg()));
            end else begin
                send(op_word(any_reg(), any_reg(), any_reg()));
            end
        end
        end_test();

        start_test("rollback");
        for (int i = 0; i < 6; i++) begin
            send(op_word(arch_idx_t'(i + 10), any_reg(), any_reg()));
        end
        // Leftover entry plus writers of x10..x12
        repeat (4) begin
            retire = 1'b1;
            tick();
        end
        // Retire in the rollback cycle is dropped
        present(op_word(any_reg(), 5'd10, 5'd11));
        retire   = 1'b1;
        rollback = 1'b1;
        tick();
        withdraw();
        send(op_word(any_reg(), 5'd10, 5'd12));
        send(op_word(any_reg(), 5'd13, 5'd15));
        end_test();

        $display("%0d tests, %0d failed, %0d mismatches, %0d timeouts",
                 tests_run, tests_failed, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: dispatch.f
+incdir+common
common/dispatch_pkg.sv
hw/inst_decoder.sv
hw/rename/map_table.sv
hw/rename/free_list.sv
hw/reorder_buffer.sv
hw/dispatch.sv
verification/dispatch_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the dispatch testbench with Verilator, run it and search the log
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module dispatch_tb \
    -f dispatch.f -o dispatch_sim \
    && ./obj_dir/dispatch_sim | tee sim.log \
    && grep -qx "TESTBENCH PASSED" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
